// ==== verification/rv_execute_testdata.txt ====
// columns: instr rs1 rs2 pc expected, all hexadecimal
// groups: OP base, OP_IMM, LUI/AUIPC, MUL/MULH, DIV/REM, other opcodes
002081B3 00000005 00000007 00001000 0000000C
402081B3 00000003 00000005 00001004 FFFFFFFE
402081B3 80000000 00000001 00001008 7FFFFFFF
002091B3 00000001 00000024 0000100C 00000010
0020A1B3 FFFFFFFF 00000001 00001010 00000001
0020A1B3 00000005 FFFFFFFB 00001014 00000000
0020B1B3 FFFFFFFF 00000001 00001018 00000000
0020B1B3 00000001 FFFFFFFF 0000101C 00000001
0020C1B3 F0F0F0F0 0FF00FF0 00001020 FF00FF00
0020D1B3 80000000 00000021 00001024 40000000
4020D1B3 80000000 00000004 00001028 F8000000
4020D1B3 7FFFFFF0 00000004 0000102C 07FFFFFF
0020E1B3 0000F000 000000F0 00001030 0000F0F0
0020F1B3 FF00FF00 0FF00FF0 00001034 0F000F00
FFF08193 00000010 12345678 00001038 0000000F
80008193 00001000 00000000 0000103C 00000800
FFF0B193 00000005 00000000 00001040 00000001
FFF0A193 FFFFFFFE 00000000 00001044 00000001
0040D193 80000000 00000000 00001048 08000000
4040D193 80000000 00000000 0000104C F8000000
7FF0C193 0000FFFF 00000000 00001050 0000F800
FF00F193 12345678 00000000 00001054 12345670
01F09193 00000003 00000000 00001058 80000000
123451B7 DEADBEEF 11111111 00002000 12345000
00001197 AAAAAAAA 55555555 00000400 00001400
FFFFF197 00000000 00000000 00002000 00001000
022081B3 00000007 00000006 0000105C 0000002A
022081B3 FFFFFFFD 00000005 00001060 FFFFFFF1
022091B3 FFFFFFFD 00000005 00001064 FFFFFFFF
022091B3 80000000 80000000 00001068 40000000
022091B3 12345678 00010000 0000106C 00001234
0220C1B3 FFFFFFF9 00000002 00001070 FFFFFFFD
0220C1B3 00000064 00000007 00001074 0000000E
0220C1B3 00000005 00000000 00001078 FFFFFFFF
0220C1B3 80000000 FFFFFFFF 0000107C 80000000
0220D1B3 FFFFFFF9 00000002 00001080 7FFFFFFC
0220D1B3 12345678 00000000 00001084 FFFFFFFF
0220E1B3 FFFFFFF9 00000002 00001088 FFFFFFFF
0220E1B3 00000064 00000007 0000108C 00000002
0220E1B3 FFFFFFF9 00000000 00001090 FFFFFFF9
0220E1B3 80000000 FFFFFFFF 00001094 00000000
0220F1B3 FFFFFFF9 00000002 00001098 00000001
0220F1B3 00000064 00000000 0000109C 00000064
0020A023 00000100 00000023 000010A0 00000123
00208063 7FFFFFFF 00000001 000010A4 80000000
0220A1B3 FFFFFFFF 00000001 000010A8 00000001

// ==== rv_execute.f ====
hdl/rv_pkg.sv
hdl/alu_ctrl.sv
hdl/alu.sv
hdl/divider.sv
hdl/rv_execute.sv
verification/rv_execute_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv_execute testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --timing --top-module rv_execute_tb -Mdir obj_dir -f rv_execute.f
status=$?
if [ $status -ne 0 ]; then
        echo "verilator build failed with status $status"
        exit 1
fi

./obj_dir/Vrv_execute_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "^No errors$" "$log"; then
        exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== verification/rv_execute_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute_tb;

localparam int done_timeout = 100;

logic                    clk;
logic                    rst_n;
logic                    issue;
logic [31:0]             instr;
logic [rv_pkg::xlen-1:0] rs1_val;
logic [rv_pkg::xlen-1:0] rs2_val;
logic [rv_pkg::xlen-1:0] pc;
logic [rv_pkg::xlen-1:0] result;
logic                    done;
logic                    busy;

rv_execute rv_execute_i (
        .clk(clk),
        .rst_n(rst_n),
        .issue(issue),
        .instr(instr),
        .rs1_val(rs1_val),
        .rs2_val(rs2_val),
        .pc(pc),
        .result(result),
        .done(done),
        .busy(busy)
);

initial
begin
        clk = 1'b0;
        forever #4 clk = ~clk;
end

task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
endtask

// M extension divide group is OP with funct7 0000001 and funct3 1xx
function automatic logic is_divide(input logic [31:0] word);
        return (word[6:0] == 7'b0110011) && (word[31:25] == 7'b0000001) && word[14];
endfunction

task automatic run_vector(input logic [31:0] v_instr, input logic [31:0] v_rs1,
                          input logic [31:0] v_rs2, input logic [31:0] v_pc,
                          input logic [31:0] expected);
        int   waited;
        logic div_op;

        waited = 0;
        div_op = is_divide(v_instr);

        @(posedge clk);
        issue <= 1'b1;
        instr <= v_instr;
        rs1_val <= v_rs1;
        rs2_val <= v_rs2;
        pc <= v_pc;
        @(posedge clk);
        issue <= 1'b0;

        do
        begin
                @(negedge clk);
                waited++;
                if (!done)
                        assert (busy === 1'b1) // Divide still running
                        else fail_run($sformatf("error at %0t: busy expected 1, actual %b",
                                                $time, busy));
        end
        while (!done && waited < done_timeout);

        if (!done)
                fail_run($sformatf("done never came for instruction %h", v_instr));

        assert (result === expected)
        else fail_run($sformatf("error at %0t: result expected %h, actual %h",
                                $time, expected, result));
        if (!div_op)
                assert (waited == 1)
                else fail_run($sformatf("done came %0d cycles after issue instead of one",
                                        waited));
        assert (busy === 1'b0)
        else fail_run($sformatf("error at %0t: busy expected 0, actual %b", $time, busy));

        @(negedge clk);
        assert (done === 1'b0)
        else fail_run($sformatf("error at %0t: done expected 0, actual %b", $time, done));
endtask

initial
begin
        int          fd;
        int          count;
        int          n_vec;
        int unsigned gap;
        string       line;
        logic [31:0] v_instr;
        logic [31:0] v_rs1;
        logic [31:0] v_rs2;
        logic [31:0] v_pc;
        logic [31:0] v_exp;

        rst_n <= 1'b0;
        issue <= 1'b0;
        instr <= '0;
        rs1_val <= '0;
        rs2_val <= '0;
        pc <= '0;
        n_vec = 0;
        void'($urandom(32'hf149_71a7));

        repeat (16) @(posedge clk);
        assert (result === '0)
        else fail_run($sformatf("error at %0t: result expected %h, actual %h",
                                $time, 32'h0, result));
        assert (done === 1'b0)
        else fail_run($sformatf("error at %0t: done expected 0, actual %b", $time, done));
        assert (busy === 1'b0)
        else fail_run($sformatf("error at %0t: busy expected 0, actual %b", $time, busy));
        rst_n <= 1'b1;

        fd = $fopen("verification/rv_execute_testdata.txt", "r");
        if (fd == 0)
                fail_run("could not open the test vector file");

        while (!$feof(fd))
        begin
                line = "";
                void'($fgets(line, fd));
                count = $sscanf(line, "%h %h %h %h %h", v_instr, v_rs1, v_rs2, v_pc, v_exp);
                if (count == 5) // Comment and blank lines do not parse
                begin
                        gap = $urandom % 4;
                        repeat (gap) @(posedge clk);
                        run_vector(v_instr, v_rs1, v_rs2, v_pc, v_exp);
                        n_vec++;
                end
        end
        $fclose(fd);

        if (n_vec == 0)
                fail_run("no test vectors were read");
        else
        begin
                $display("No errors");
                $finish;
        end
end

endmodule

`default_nettype wire

// ==== hdl/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
        input  wire logic                    clk,
        input  wire logic                    rst_n,
        input  wire logic                    issue,
        input  wire logic [31:0]             instr,
        input  wire logic [rv_pkg::xlen-1:0] rs1_val,
        input  wire logic [rv_pkg::xlen-1:0] rs2_val,
        input  wire logic [rv_pkg::xlen-1:0] pc,
        output logic [rv_pkg::xlen-1:0]      result,
        output logic                         done,
        output logic                         busy
);

typedef enum logic {
        IDLE,
        DIV_WAIT
} exec_state_t;

exec_state_t                    state;
rv_pkg::instruction_format_type opcode;
logic [2:0]                     funct3;
logic [6:0]                     funct7;
logic [rv_pkg::xlen-1:0]        imm_i;
logic [rv_pkg::xlen-1:0]        imm_u;
rv_pkg::alu_operation_type      op;
rv_pkg::exec_req_t              req;
logic                           is_div;
logic                           div_start;
logic                           div_valid;
logic [rv_pkg::xlen-1:0]        div_y;
logic [rv_pkg::xlen-1:0]        alu_y;

assign opcode = rv_pkg::instruction_format_type'(instr[6:0]);
assign funct3 = instr[14:12];
assign funct7 = instr[31:25];

assign imm_i = {{(rv_pkg::xlen-12){instr[31]}}, instr[31:20]};
assign imm_u = {instr[31:12], 12'b0};

alu_ctrl alu_ctrl_i (
        .funct3(funct3),
        .funct7(funct7),
        .opcode(opcode),
        .op(op)
);

always_comb
begin
        req.op = op;
        req.a = (opcode == rv_pkg::U_AUIPC) ? pc : rs1_val;
        case (opcode)
                rv_pkg::OP_IMM:
                        req.b = imm_i;
                rv_pkg::U_LUI, rv_pkg::U_AUIPC:
                        req.b = imm_u;
                default:
                        req.b = rs2_val; // OP and the ADD fallback
        endcase
end

assign is_div = op inside {rv_pkg::DIV, rv_pkg::DIVU, rv_pkg::REM, rv_pkg::REMU};
assign div_start = issue && is_div;

alu alu_i (
        .req(req),
        .y(alu_y)
);

divider divider_i (
        .clk(clk),
        .rst_n(rst_n),
        .start(div_start),
        .req(req),
        .valid(div_valid),
        .y(div_y)
);

assign busy = (state == DIV_WAIT);

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
        begin
                state <= IDLE;
                result <= '0;
                done <= 1'b0;
        end
        else
        begin
                done <= 1'b0;
                case (state)
                        IDLE:
                        begin
                                if (div_start)
                                        state <= DIV_WAIT;
                                else if (issue)
                                begin
                                        result <= alu_y;    // Single cycle path
                                        done <= 1'b1;
                                end
                        end
                        DIV_WAIT:
                        begin
                                if (div_valid)
                                begin
                                        result <= div_y;
                                        done <= 1'b1;
                                        state <= IDLE;
                                end
                        end
                endcase
        end
end

a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n) issue |-> !busy)
        else $error("issue while the stage is busy");

// A done out of IDLE needs an issue in the cycle before
a_done_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
        (done && $past(state == IDLE)) |-> $past(issue))
        else $error("done without a preceding issue");

endmodule

`default_nettype wire

// ==== hdl/divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module divider (
        input  wire logic               clk,
        input  wire logic               rst_n,
        input  wire logic               start,
        input  wire rv_pkg::exec_req_t  req,
        output logic                    valid,
        output logic [rv_pkg::xlen-1:0] y
);

logic [rv_pkg::div_cnt_w-1:0] count;
logic                         busy;
logic                         is_signed;
logic                         a_neg;
logic                         b_neg;
logic [rv_pkg::xlen-1:0]      rem;
logic [rv_pkg::xlen-1:0]      quo;
logic [rv_pkg::xlen-1:0]      dvs;
logic                         neg_quo;
logic                         neg_rem;
logic                         sel_rem;
logic [rv_pkg::xlen:0]        rem_shift;
logic [rv_pkg::xlen:0]        trial;
logic [rv_pkg::xlen-1:0]      rem_next;
logic [rv_pkg::xlen-1:0]      quo_next;
logic [rv_pkg::xlen-1:0]      quo_out;
logic [rv_pkg::xlen-1:0]      rem_out;

assign busy = (count != '0);

assign is_signed = (req.op == rv_pkg::DIV) || (req.op == rv_pkg::REM);
assign a_neg = is_signed && req.a[rv_pkg::xlen-1];
assign b_neg = is_signed && req.b[rv_pkg::xlen-1];

// Dividend bits shift from quo into the partial remainder
assign rem_shift = {rem, quo[rv_pkg::xlen-1]};
assign trial = rem_shift - {1'b0, dvs};
assign rem_next = trial[rv_pkg::xlen] ? rem_shift[rv_pkg::xlen-1:0] : trial[rv_pkg::xlen-1:0];
assign quo_next = {quo[rv_pkg::xlen-2:0], ~trial[rv_pkg::xlen]};

assign quo_out = neg_quo ? -quo_next : quo_next;
assign rem_out = neg_rem ? -rem_next : rem_next;    // Sign follows the dividend

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
        begin
                count <= '0;
                valid <= 1'b0;
        end
        else
        begin
                valid <= busy && (count == 1);
                if (start)
                        count <= rv_pkg::div_steps;
                else if (busy)
                        count <= count - 1'b1;
        end
end

always_ff @(posedge clk)
begin
        if (start)
        begin
                rem <= '0;
                quo <= a_neg ? -req.a : req.a;
                dvs <= b_neg ? -req.b : req.b;
                // Zero divisor leaves the all ones quotient unsigned
                neg_quo <= (a_neg ^ b_neg) && (req.b != '0);
                neg_rem <= a_neg;
                sel_rem <= (req.op == rv_pkg::REM) || (req.op == rv_pkg::REMU);
        end
        else if (busy)
        begin
                rem <= rem_next;
                quo <= quo_next;
        end

        if (busy && count == 1)
                y <= sel_rem ? rem_out : quo_out;
end

a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else $error("divider started while a division is in progress");

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
        input  wire rv_pkg::exec_req_t  req,
        output logic [rv_pkg::xlen-1:0] y
);

logic signed [2*rv_pkg::xlen-1:0] prod;
logic [rv_pkg::shamt_w-1:0]       shamt;

assign prod = $signed(req.a) * $signed(req.b); // Signed by signed
assign shamt = req.b[rv_pkg::shamt_w-1:0];

always_comb
begin
        case (req.op)
                rv_pkg::ADD, rv_pkg::AUIPC:
                        y = req.a + req.b;
                rv_pkg::SUB:
                        y = req.a - req.b;
                rv_pkg::SLL:
                        y = req.a << shamt;
                rv_pkg::SLT:
                        y = {{(rv_pkg::xlen-1){1'b0}}, $signed(req.a) < $signed(req.b)};
                rv_pkg::SLTU:
                        y = {{(rv_pkg::xlen-1){1'b0}}, req.a < req.b};
                rv_pkg::XOR:
                        y = req.a ^ req.b;
                rv_pkg::SRL:
                        y = req.a >> shamt;
                rv_pkg::SRA:
                        y = $unsigned($signed(req.a) >>> shamt);
                rv_pkg::OR:
                        y = req.a | req.b;
                rv_pkg::AND:
                        y = req.a & req.b;
                rv_pkg::LUI:
                        y = req.b;
                rv_pkg::MUL:
                        y = prod[rv_pkg::xlen-1:0];
                rv_pkg::MULH:
                        y = prod[2*rv_pkg::xlen-1:rv_pkg::xlen];
                default:
                        y = '0; // Divides are handled by the divider
        endcase
end

endmodule

`default_nettype wire

// ==== hdl/alu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_ctrl (
        input  wire [2:0]                           funct3,
        input  wire [6:0]                           funct7,
        input  wire rv_pkg::instruction_format_type opcode,
        output rv_pkg::alu_operation_type           op
);

always_comb
begin
        op = rv_pkg::ADD;

        case (opcode)
                rv_pkg::OP, rv_pkg::OP_IMM:
                begin
                        case (funct3)
                                3'b000: op = rv_pkg::ADD;
                                3'b001: op = rv_pkg::SLL;
                                3'b010: op = rv_pkg::SLT;
                                3'b011: op = rv_pkg::SLTU;
                                3'b100: op = rv_pkg::XOR;
                                3'b101: op = rv_pkg::SRL;
                                3'b110: op = rv_pkg::OR;
                                3'b111: op = rv_pkg::AND;
                        endcase

                        // SRAI shares the funct7 encoding with SRA
                        if (funct3 == 3'b101 && funct7 == rv_pkg::alt_funct7)
                                op = rv_pkg::SRA;

                        if (opcode == rv_pkg::OP)
                        begin
                                if (funct3 == 3'b000 && funct7 == rv_pkg::alt_funct7)
                                        op = rv_pkg::SUB;
                                else if (funct7 == rv_pkg::m_funct7)
                                begin
                                        case (funct3)
                                                3'b000: op = rv_pkg::MUL;
                                                3'b001: op = rv_pkg::MULH;
                                                3'b010: op = rv_pkg::SLT;   // No MULHSU
                                                3'b011: op = rv_pkg::SLTU;  // No MULHU
                                                3'b100: op = rv_pkg::DIV;
                                                3'b101: op = rv_pkg::DIVU;
                                                3'b110: op = rv_pkg::REM;
                                                3'b111: op = rv_pkg::REMU;
                                        endcase
                                end
                        end
                end
                rv_pkg::U_LUI:
                        op = rv_pkg::LUI;
                rv_pkg::U_AUIPC:
                        op = rv_pkg::AUIPC;
                default:
                        op = rv_pkg::ADD; // Unsupported opcodes fall back to rs1 + rs2
        endcase
end

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

        localparam int xlen = 32;
        localparam int shamt_w = $clog2(xlen);

        localparam logic [6:0] m_funct7 = 7'b0000001;
        localparam logic [6:0] alt_funct7 = 7'b0100000;

        // Divider step counter
        localparam int div_cnt_w = $clog2(xlen + 1);
        localparam logic [div_cnt_w-1:0] div_steps = div_cnt_w'(xlen);

        // Major opcodes in instr[6:0]
        typedef enum logic [6:0] {
                LOAD     = 7'b0000011,
                MISC_MEM = 7'b0001111,
                OP_IMM   = 7'b0010011,
                U_AUIPC  = 7'b0010111,
                STORE    = 7'b0100011,
                OP       = 7'b0110011,
                U_LUI    = 7'b0110111,
                BRANCH   = 7'b1100011,
                JALR     = 7'b1100111,
                J_JAL    = 7'b1101111,
                SYSTEM   = 7'b1110011
        } instruction_format_type;

        typedef enum logic [4:0] {
                ADD,
                SUB,
                SLL,
                SLT,
                SLTU,
                XOR,
                SRL,
                SRA,
                OR,
                AND,
                LUI,
                AUIPC,
                MUL,
                MULH,
                DIV,
                DIVU,
                REM,
                REMU
        } alu_operation_type;

        typedef struct packed {
                alu_operation_type op;
                logic [xlen-1:0]   a;
                logic [xlen-1:0]   b;
        } exec_req_t;

endpackage

`default_nettype wire
